// File: source/aluPkg.sv
package aluPkg;

    localparam int DataWidth = 32;
    localparam int OpWidth = 6;

    // Iteration counts of the serial units
    localparam int SqrtIterations = 16;
    localparam int DivIterations = 32;
    localparam int SqrtCntWidth = $clog2(SqrtIterations);
    localparam int DivCntWidth = $clog2(DivIterations);

    // Function codes as the core sends them
    typedef enum logic [OpWidth-1:0] {
        opIntAdd       = 6'b000000,
        opIntSub       = 6'b000001,
        opIntMul       = 6'b000010,
        opIntSqrt      = 6'b000011,
        opIntDiv       = 6'b000100,
        opIntMod       = 6'b000101,
        opShiftLeft    = 6'b000110,
        opShiftRight   = 6'b000111,
        opEqual        = 6'b010000,
        opNotEqual     = 6'b010001,
        opGreater      = 6'b010010,
        opGreaterEqual = 6'b010011,
        opLess         = 6'b010100,
        opLessEqual    = 6'b010101,
        opNot          = 6'b011000,
        opAnd          = 6'b011001,
        opOr           = 6'b011010,
        opXor          = 6'b011011,
        opXnor         = 6'b011100
    } aluOp_t;

    typedef enum logic [1:0] {
        unitSimple,
        unitSqrt,
        unitDiv
    } unitSel_t;

endpackage

// File: source/aluIssueIf.sv
`timescale 1ns/1ps

interface aluIssueIf;

    logic [aluPkg::DataWidth-1:0] operandA;
    logic [aluPkg::DataWidth-1:0] operandB;
    aluPkg::aluOp_t op;

    // One-cycle unit starts, never more than one at a time
    logic startSimple;
    logic startSqrt;
    logic startDiv;

    modport issue (
        output operandA, operandB, op, startSimple, startSqrt, startDiv
    );

    modport unit (
        input operandA, operandB, op, startSimple, startSqrt, startDiv
    );

endinterface

// File: source/aluIssue.sv
`timescale 1ns/1ps

module aluIssue (
    input  logic                         Clock,
    input  logic                         i_rstN,
    input  logic                         i_start,
    input  logic [aluPkg::DataWidth-1:0] i_operandA,
    input  logic [aluPkg::DataWidth-1:0] i_operandB,
    input  logic [aluPkg::OpWidth-1:0]   i_funcCode,
    input  logic                         i_busy,
    aluIssueIf.issue                     o_issue
);

    aluPkg::aluOp_t decodedOp;
    aluPkg::unitSel_t decodedUnit;
    aluPkg::unitSel_t unitReg;
    logic pending;
    logic accept;

    assign accept = i_start && !i_busy; // Starts while busy are dropped
    assign decodedOp = aluPkg::aluOp_t'(i_funcCode);

    always_comb begin
        case (decodedOp)
            aluPkg::opIntSqrt: decodedUnit = aluPkg::unitSqrt;
            aluPkg::opIntDiv,
            aluPkg::opIntMod:  decodedUnit = aluPkg::unitDiv;
            default:           decodedUnit = aluPkg::unitSimple; // Unknown codes too
        endcase
    end

    // Request payload, held until the next accept
    always_ff @(posedge Clock) begin
        if (accept) begin
            o_issue.operandA <= i_operandA;
            o_issue.operandB <= i_operandB;
            o_issue.op <= decodedOp;
            unitReg <= decodedUnit;
        end
    end

    always_ff @(posedge Clock) begin
        if (!i_rstN) begin
            pending <= 1'b0;
            o_issue.startSimple <= 1'b0;
            o_issue.startSqrt <= 1'b0;
            o_issue.startDiv <= 1'b0;
        end else begin
            pending <= accept;
            o_issue.startSimple <= pending && unitReg == aluPkg::unitSimple;
            o_issue.startSqrt <= pending && unitReg == aluPkg::unitSqrt;
            o_issue.startDiv <= pending && unitReg == aluPkg::unitDiv;
        end
    end

    // One strobe per request, never two in successive cycles
    startOnePerRequest: assert property (@(posedge Clock) disable iff (!i_rstN)
        (o_issue.startSimple || o_issue.startSqrt || o_issue.startDiv)
            |=> !(o_issue.startSimple || o_issue.startSqrt || o_issue.startDiv));

endmodule

// File: source/aluSimpleUnit.sv
`timescale 1ns/1ps

module aluSimpleUnit (
    input  logic                         Clock,
    input  logic                         i_rstN,
    aluIssueIf.unit                      i_issue,
    output logic                         o_finish,
    output logic [aluPkg::DataWidth-1:0] o_result
);

    logic [aluPkg::DataWidth-1:0] a;
    logic [aluPkg::DataWidth-1:0] b;

    assign a = i_issue.operandA;
    assign b = i_issue.operandB;

    always_ff @(posedge Clock) begin
        if (i_issue.startSimple) begin
            case (i_issue.op)
                aluPkg::opIntAdd:       o_result <= $signed(a) + $signed(b);
                aluPkg::opIntSub:       o_result <= $signed(a) - $signed(b);
                aluPkg::opIntMul:       o_result <= $signed(a) * $signed(b); // Low word only
                aluPkg::opShiftLeft:    o_result <= a << b[4:0];
                aluPkg::opShiftRight:   o_result <= a >> b[4:0];
                // Unsigned compares
                aluPkg::opEqual:        o_result <= aluPkg::DataWidth'(a == b);
                aluPkg::opNotEqual:     o_result <= aluPkg::DataWidth'(a != b);
                aluPkg::opGreater:      o_result <= aluPkg::DataWidth'(a > b);
                aluPkg::opGreaterEqual: o_result <= aluPkg::DataWidth'(a >= b);
                aluPkg::opLess:         o_result <= aluPkg::DataWidth'(a < b);
                aluPkg::opLessEqual:    o_result <= aluPkg::DataWidth'(a <= b);
                aluPkg::opNot:          o_result <= ~a;
                aluPkg::opAnd:          o_result <= a & b;
                aluPkg::opOr:           o_result <= a | b;
                aluPkg::opXor:          o_result <= a ^ b;
                aluPkg::opXnor:         o_result <= a ~^ b;
                default:                o_result <= '0;
            endcase
        end
    end

    always_ff @(posedge Clock) begin
        if (!i_rstN) begin
            o_finish <= 1'b0;
        end else begin
            o_finish <= i_issue.startSimple;
        end
    end

endmodule

// File: source/intSqrtUnit.sv
`timescale 1ns/1ps

module intSqrtUnit (
    input  logic                         Clock,
    input  logic                         i_rstN,
    aluIssueIf.unit                      i_issue,
    output logic                         o_finish,
    output logic [aluPkg::DataWidth-1:0] o_result
);

    typedef enum logic {sqrtIdle, sqrtRun} sqrtState_t;

    sqrtState_t state;
    logic [aluPkg::SqrtCntWidth-1:0] iterCnt;
    logic signed [aluPkg::DataWidth/2+5:0] remReg;
    logic signed [aluPkg::DataWidth/2+5:0] remIn;
    logic signed [aluPkg::DataWidth/2+5:0] remShift;
    logic signed [aluPkg::DataWidth/2+5:0] trial;
    logic signed [aluPkg::DataWidth/2+5:0] remNext;
    logic [aluPkg::DataWidth/2-1:0] rootReg;
    logic [aluPkg::DataWidth/2-1:0] rootIn;
    logic [aluPkg::DataWidth-1:0] radReg;
    logic [aluPkg::DataWidth-1:0] radIn;
    logic step;

    assign step = i_issue.startSqrt || state == sqrtRun;

    // First bit pair is taken straight from the operand on start
    always_comb begin
        remIn = i_issue.startSqrt ? '0 : remReg;
        rootIn = i_issue.startSqrt ? '0 : rootReg;
        radIn = i_issue.startSqrt ? i_issue.operandA : radReg;
        remShift = $signed({remIn[aluPkg::DataWidth/2+3:0], radIn[aluPkg::DataWidth-1 -: 2]});
        // Subtract {root,01} or add back {root,11}
        trial = {rootIn, remIn[aluPkg::DataWidth/2+5], 1'b1};
        remNext = remIn[aluPkg::DataWidth/2+5] ? remShift + trial : remShift - trial;
    end

    always_ff @(posedge Clock) begin
        if (step) begin
            remReg <= remNext;
            rootReg <= {rootIn[aluPkg::DataWidth/2-2:0], ~remNext[aluPkg::DataWidth/2+5]};
            radReg <= radIn << 2;
        end
    end

    always_ff @(posedge Clock) begin
        if (!i_rstN) begin
            state <= sqrtIdle;
            iterCnt <= '0;
            o_finish <= 1'b0;
        end else begin
            o_finish <= 1'b0;
            case (state)
                sqrtIdle: begin
                    if (i_issue.startSqrt) begin
                        state <= sqrtRun;
                        iterCnt <= aluPkg::SqrtCntWidth'(1);
                    end
                end
                sqrtRun: begin
                    iterCnt <= iterCnt + 1'b1;
                    if (iterCnt == aluPkg::SqrtCntWidth'(aluPkg::SqrtIterations - 1)) begin
                        state <= sqrtIdle;
                        o_finish <= 1'b1;
                    end
                end
                default: state <= sqrtIdle;
            endcase
        end
    end

    assign o_result = aluPkg::DataWidth'(rootReg);

    noStartWhileRunning: assert property (@(posedge Clock) disable iff (!i_rstN)
        i_issue.startSqrt |-> state == sqrtIdle);

endmodule

// File: source/intDivUnit.sv
`timescale 1ns/1ps

module intDivUnit (
    input  logic                         Clock,
    input  logic                         i_rstN,
    aluIssueIf.unit                      i_issue,
    output logic                         o_finish,
    output logic [aluPkg::DataWidth-1:0] o_result
);

    typedef enum logic {divIdle, divRun} divState_t;

    divState_t state;
    logic [aluPkg::DivCntWidth-1:0] iterCnt;
    logic [aluPkg::DataWidth-1:0] remReg;
    logic [aluPkg::DataWidth-1:0] quoReg;
    logic [aluPkg::DataWidth-1:0] remIn;
    logic [aluPkg::DataWidth-1:0] quoIn;
    logic [aluPkg::DataWidth:0] remShift;
    logic [aluPkg::DataWidth:0] diff;
    logic fits;
    logic step;

    assign step = i_issue.startDiv || state == divRun;

    // Quotient register starts as the dividend and shifts it out MSB first
    always_comb begin
        remIn = i_issue.startDiv ? '0 : remReg;
        quoIn = i_issue.startDiv ? i_issue.operandA : quoReg;
        remShift = {remIn, quoIn[aluPkg::DataWidth-1]};
        diff = remShift - {1'b0, i_issue.operandB}; // Divisor stays stable on the bus
        fits = !diff[aluPkg::DataWidth];
    end

    always_ff @(posedge Clock) begin
        if (step) begin
            remReg <= fits ? diff[aluPkg::DataWidth-1:0] : remShift[aluPkg::DataWidth-1:0];
            quoReg <= {quoIn[aluPkg::DataWidth-2:0], fits};
        end
    end

    always_ff @(posedge Clock) begin
        if (!i_rstN) begin
            state <= divIdle;
            iterCnt <= '0;
            o_finish <= 1'b0;
        end else begin
            o_finish <= 1'b0;
            case (state)
                divIdle: begin
                    if (i_issue.startDiv) begin
                        state <= divRun;
                        iterCnt <= aluPkg::DivCntWidth'(1);
                    end
                end
                divRun: begin
                    iterCnt <= iterCnt + 1'b1;
                    if (iterCnt == aluPkg::DivCntWidth'(aluPkg::DivIterations - 1)) begin
                        state <= divIdle;
                        o_finish <= 1'b1;
                    end
                end
                default: state <= divIdle;
            endcase
        end
    end

    // Zero divisor falls out as all-ones quotient and remainder equal to A
    assign o_result = (i_issue.op == aluPkg::opIntMod) ? remReg : quoReg;

    noStartWhileRunning: assert property (@(posedge Clock) disable iff (!i_rstN)
        i_issue.startDiv |-> state == divIdle);

endmodule

// File: source/aluRetire.sv
`timescale 1ns/1ps

module aluRetire (
    input  logic                         Clock,
    input  logic                         i_rstN,
    input  logic                         i_accept,
    input  logic                         i_simpleFinish,
    input  logic                         i_sqrtFinish,
    input  logic                         i_divFinish,
    input  logic [aluPkg::DataWidth-1:0] i_simpleResult,
    input  logic [aluPkg::DataWidth-1:0] i_sqrtResult,
    input  logic [aluPkg::DataWidth-1:0] i_divResult,
    output logic                         o_busy,
    output logic                         o_done,
    output logic [aluPkg::DataWidth-1:0] o_result
);

    logic anyFinish;

    assign anyFinish = i_simpleFinish || i_sqrtFinish || i_divFinish;

    always_ff @(posedge Clock) begin
        if (!i_rstN) begin
            o_busy <= 1'b0;
            o_result <= '0;
        end else begin
            if (i_accept) begin
                o_busy <= 1'b1;
            end else if (anyFinish) begin
                o_busy <= 1'b0;
            end
            // Result holds until the next unit finishes
            if (i_simpleFinish) begin
                o_result <= i_simpleResult;
            end else if (i_sqrtFinish) begin
                o_result <= i_sqrtResult;
            end else if (i_divFinish) begin
                o_result <= i_divResult;
            end
        end
    end

    assign o_done = !o_busy;

    singleFinish: assert property (@(posedge Clock) disable iff (!i_rstN)
        $onehot0({i_simpleFinish, i_sqrtFinish, i_divFinish}));

endmodule

// File: source/aluTop.sv
`timescale 1ns/1ps

module aluTop (
    input  logic                         Clock,
    input  logic                         i_rstN,
    input  logic                         i_start,
    input  logic [aluPkg::DataWidth-1:0] i_operandA,
    input  logic [aluPkg::DataWidth-1:0] i_operandB,
    input  logic [aluPkg::OpWidth-1:0]   i_funcCode,
    output logic                         o_done,
    output logic [aluPkg::DataWidth-1:0] o_result
);

    logic busy;
    logic accept;
    logic simpleFinish;
    logic sqrtFinish;
    logic divFinish;
    logic [aluPkg::DataWidth-1:0] simpleResult;
    logic [aluPkg::DataWidth-1:0] sqrtResult;
    logic [aluPkg::DataWidth-1:0] divResult;

    aluIssueIf issueBus ();

    assign accept = i_start && !busy;

    aluIssue issue0 (
        .Clock      (Clock),
        .i_rstN     (i_rstN),
        .i_start    (i_start),
        .i_operandA (i_operandA),
        .i_operandB (i_operandB),
        .i_funcCode (i_funcCode),
        .i_busy     (busy),
        .o_issue    (issueBus.issue)
    );

    aluSimpleUnit simple0 (
        .Clock    (Clock),
        .i_rstN   (i_rstN),
        .i_issue  (issueBus.unit),
        .o_finish (simpleFinish),
        .o_result (simpleResult)
    );

    intSqrtUnit sqrt0 (
        .Clock    (Clock),
        .i_rstN   (i_rstN),
        .i_issue  (issueBus.unit),
        .o_finish (sqrtFinish),
        .o_result (sqrtResult)
    );

    intDivUnit div0 (
        .Clock    (Clock),
        .i_rstN   (i_rstN),
        .i_issue  (issueBus.unit),
        .o_finish (divFinish),
        .o_result (divResult)
    );

    aluRetire retire0 (
        .Clock          (Clock),
        .i_rstN         (i_rstN),
        .i_accept       (accept),
        .i_simpleFinish (simpleFinish),
        .i_sqrtFinish   (sqrtFinish),
        .i_divFinish    (divFinish),
        .i_simpleResult (simpleResult),
        .i_sqrtResult   (sqrtResult),
        .i_divResult    (divResult),
        .o_busy         (busy),
        .o_done         (o_done),
        .o_result       (o_result)
    );

endmodule

// File: test/aluTb.sv
`timescale 1ns/1ps

module aluTb;

    localparam int RandomRows = 40;
    localparam int CyclesPerRow = 40;

    typedef struct {
        logic [5:0]  code;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] expected;
        bit          stray;     // Extra start pulse while busy
    } row_t;

    logic        Clock;
    logic        i_rstN;
    logic        i_start;
    logic [31:0] i_operandA;
    logic [31:0] i_operandB;
    logic [5:0]  i_funcCode;
    logic        o_done;
    logic [31:0] o_result;

    row_t rows [$];
    logic [5:0] opList [19];
    integer seed;
    int cycleCount = 0;
    int cycleLimit = 0;

    aluTop dut0 (
        .Clock      (Clock),
        .i_rstN     (i_rstN),
        .i_start    (i_start),
        .i_operandA (i_operandA),
        .i_operandB (i_operandB),
        .i_funcCode (i_funcCode),
        .o_done     (o_done),
        .o_result   (o_result)
    );

    initial begin
        Clock = 1'b0;
        forever #20 Clock = ~Clock;
    end

    always @(posedge Clock) begin
        cycleCount++;
        if (cycleLimit != 0 && cycleCount >= cycleLimit) begin
            $display("Timeout: the run did not finish within %0d clock cycles", cycleLimit);
            $display("Simulation FAILED");
            $fatal(1, "timeout");
        end
    end

    task automatic checkEqual(input logic [31:0] actual, input logic [31:0] expected,
                              input string what);
        if (actual !== expected) begin
            $display("ERR %0t: %s got %h expected %h", $time, what, actual, expected);
            $display("Simulation FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    function automatic logic [31:0] floorSqrt(input logic [31:0] v);
        logic [31:0] r;
        logic [63:0] t;
        r = '0;
        for (int i = 15; i >= 0; i--) begin
            t = {32'b0, r | (32'd1 << i)};
            if (t * t <= {32'b0, v}) r = r | (32'd1 << i);
        end
        return r;
    endfunction

    function automatic logic [31:0] refModel(input logic [5:0] code, input logic [31:0] a,
                                             input logic [31:0] b);
        logic [31:0] r;
        case (code)
            aluPkg::opIntAdd:       r = a + b;
            aluPkg::opIntSub:       r = a - b;
            aluPkg::opIntMul:       r = a * b;          // Low word is sign independent
            aluPkg::opIntSqrt:      r = floorSqrt(a);
            aluPkg::opIntDiv:       r = (b == 0) ? 32'hFFFFFFFF : a / b;
            aluPkg::opIntMod:       r = (b == 0) ? a : a % b;
            aluPkg::opShiftLeft:    r = a << b[4:0];
            aluPkg::opShiftRight:   r = a >> b[4:0];
            aluPkg::opEqual:        r = {31'b0, a == b};
            aluPkg::opNotEqual:     r = {31'b0, a != b};
            aluPkg::opGreater:      r = {31'b0, a > b};
            aluPkg::opGreaterEqual: r = {31'b0, a >= b};
            aluPkg::opLess:         r = {31'b0, a < b};
            aluPkg::opLessEqual:    r = {31'b0, a <= b};
            aluPkg::opNot:          r = ~a;
            aluPkg::opAnd:          r = a & b;
            aluPkg::opOr:           r = a | b;
            aluPkg::opXor:          r = a ^ b;
            aluPkg::opXnor:         r = ~(a ^ b);
            default:                r = '0;
        endcase
        return r;
    endfunction

    function automatic void addRow(input logic [5:0] code, input logic [31:0] a,
                                   input logic [31:0] b, input logic [31:0] expected,
                                   input bit stray);
        rows.push_back('{code, a, b, expected, stray});
    endfunction

    // Called at 2 ns after an edge where o_done is high; returns the same way
    task automatic runOp(input logic [5:0] code, input logic [31:0] a, input logic [31:0] b,
                         input logic [31:0] expected, input bit stray);
        int edges;
        bit isSimple;
        string what;
        edges = 0;
        isSimple = code != aluPkg::opIntSqrt && code != aluPkg::opIntDiv
            && code != aluPkg::opIntMod;
        what = $sformatf("code %h a %h b %h", code, a, b);
        i_funcCode = code;
        i_operandA = a;
        i_operandB = b;
        i_start = 1'b1;
        @(posedge Clock);   // Accepting edge
        #2;
        i_start = 1'b0;
        checkEqual({31'b0, o_done}, 32'd0, {what, " done after accept"});
        if (stray) begin
            i_start = 1'b1;
            i_funcCode = aluPkg::opIntSub;
            i_operandA = ~a;
            i_operandB = 32'h1;
        end
        do begin
            @(posedge Clock);
            #2;
            i_start = 1'b0;
            edges++;
        end while (!o_done);
        if (isSimple) checkEqual(edges, 32'd3, {what, " latency"});
        checkEqual(o_result, expected, what);
    endtask

    task automatic buildTable();
        addRow(aluPkg::opIntAdd, 32'd5, 32'd7, 32'd12, 0);
        addRow(aluPkg::opIntAdd, 32'h7FFFFFFF, 32'd1, 32'h80000000, 0);    // Wraps
        addRow(aluPkg::opIntSub, 32'd3, 32'd5, 32'hFFFFFFFE, 0);
        addRow(aluPkg::opIntMul, 32'hFFFFFFFD, 32'd7, 32'hFFFFFFEB, 0);
        addRow(aluPkg::opIntMul, 32'h00010000, 32'h00010000, 32'd0, 0);
        addRow(aluPkg::opShiftLeft, 32'd1, 32'h24, 32'd16, 0);
        addRow(aluPkg::opShiftRight, 32'h80000000, 32'd31, 32'd1, 0);
        addRow(aluPkg::opShiftRight, 32'hF0000000, 32'h104, 32'h0F000000, 0);
        addRow(aluPkg::opEqual, 32'd9, 32'd9, 32'd1, 0);
        addRow(aluPkg::opNotEqual, 32'd9, 32'd9, 32'd0, 0);
        addRow(aluPkg::opGreater, 32'hFFFFFFFF, 32'd1, 32'd1, 0);          // Unsigned
        addRow(aluPkg::opGreaterEqual, 32'd4, 32'd5, 32'd0, 0);
        addRow(aluPkg::opLess, 32'h80000000, 32'd1, 32'd0, 0);
        addRow(aluPkg::opLessEqual, 32'd7, 32'd7, 32'd1, 0);
        addRow(aluPkg::opNot, 32'h0F0F0F0F, 32'd0, 32'hF0F0F0F0, 0);
        addRow(aluPkg::opAnd, 32'hFF00FF00, 32'h0FF00FF0, 32'h0F000F00, 0);
        addRow(aluPkg::opOr, 32'hFF00FF00, 32'h0FF00FF0, 32'hFFF0FFF0, 0);
        addRow(aluPkg::opXor, 32'hFF00FF00, 32'h0FF00FF0, 32'hF0F0F0F0, 0);
        addRow(aluPkg::opXnor, 32'hFF00FF00, 32'h0FF00FF0, 32'h0F0F0F0F, 0);
        addRow(6'h3F, 32'd1, 32'd2, 32'd0, 0);                               // Unknown code
        addRow(aluPkg::opIntSqrt, 32'd0, 32'd0, 32'd0, 0);
        addRow(aluPkg::opIntSqrt, 32'd1, 32'd0, 32'd1, 0);
        addRow(aluPkg::opIntSqrt, 32'd144, 32'd0, 32'd12, 0);
        addRow(aluPkg::opIntSqrt, 32'd15, 32'd0, 32'd3, 0);
        addRow(aluPkg::opIntSqrt, 32'hFFFFFFFF, 32'd0, 32'h0000FFFF, 0);
        addRow(aluPkg::opIntDiv, 32'd100, 32'd7, 32'd14, 0);
        addRow(aluPkg::opIntMod, 32'd100, 32'd7, 32'd2, 0);
        addRow(aluPkg::opIntDiv, 32'd5, 32'd0, 32'hFFFFFFFF, 0);            // Zero divisor
        addRow(aluPkg::opIntMod, 32'd5, 32'd0, 32'd5, 0);
        addRow(aluPkg::opIntDiv, 32'hFFFFFFFF, 32'd1, 32'hFFFFFFFF, 0);
        addRow(aluPkg::opIntMod, 32'h12345678, 32'h00010000, 32'h00005678, 0);
        addRow(aluPkg::opIntAdd, 32'd2, 32'd3, 32'd5, 1);
        addRow(aluPkg::opIntDiv, 32'd1000, 32'd10, 32'd100, 1);
    endtask

    initial begin
        logic [5:0] code;
        logic [31:0] a;
        logic [31:0] b;
        opList = '{aluPkg::opIntAdd, aluPkg::opIntSub, aluPkg::opIntMul, aluPkg::opIntSqrt,
            aluPkg::opIntDiv, aluPkg::opIntMod, aluPkg::opShiftLeft, aluPkg::opShiftRight,
            aluPkg::opEqual, aluPkg::opNotEqual, aluPkg::opGreater, aluPkg::opGreaterEqual,
            aluPkg::opLess, aluPkg::opLessEqual, aluPkg::opNot, aluPkg::opAnd, aluPkg::opOr,
            aluPkg::opXor, aluPkg::opXnor};
        seed = 32'hb5168702;
        i_rstN = 1'b0;
        i_start = 1'b0;
        i_operandA = '0;
        i_operandB = '0;
        i_funcCode = '0;
        buildTable();
        cycleLimit = (rows.size() + RandomRows) * CyclesPerRow + 100;
        repeat (5) @(posedge Clock);
        #2;
        i_rstN = 1'b1;
        @(posedge Clock);
        #2;
        checkEqual({31'b0, o_done}, 32'd1, "done after reset");
        checkEqual(o_result, 32'd0, "result after reset");
        foreach (rows[i]) begin
            runOp(rows[i].code, rows[i].a, rows[i].b, rows[i].expected, rows[i].stray);
        end
        // Mixed random sequence
        for (int i = 0; i < RandomRows; i++) begin
            code = opList[$unsigned($random(seed)) % 19];
            a = $random(seed);
            b = $random(seed);
            if (code == aluPkg::opIntDiv || code == aluPkg::opIntMod) begin
                b = b >> ($unsigned($random(seed)) % 32);   // Spread divisor sizes
            end
            runOp(code, a, b, refModel(code, a, b), 0);
        end
        $display("Simulation PASSED");
        $finish;
    end

endmodule

// File: build.f
source/aluPkg.sv
source/aluIssueIf.sv
source/aluIssue.sv
source/aluSimpleUnit.sv
source/intSqrtUnit.sv
source/intDivUnit.sv
source/aluRetire.sv
source/aluTop.sv
test/aluTb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module aluTb -f build.f -o aluSim

simOutput=$(./obj_dir/aluSim 2>&1) || true
echo "$simOutput"

if echo "$simOutput" | grep -q "Simulation PASSED"; then
    exit 0
else
    exit 1
fi
